/* logic/cacheGeomPkg.sv */
/*
  Geometry of the instruction cache: address split, line size and way count.
  Every RTL block and the testbench take these by scoped name.
*/

`default_nettype none

package cacheGeomPkg;

  // Physical address and line size
  localparam int paBits = 32;
  localparam int lineBits = 128;

  // Organization of the arrays
  localparam int numWays = 2;
  localparam int numSets = 16;

  // Address fields, tag on top, then index, then byte offset
  localparam int offsetBits = 4;
  localparam int indexBits = 4;
  localparam int tagBits = paBits - indexBits - offsetBits;
  localparam int halvesPerLine = lineBits / 16;

  typedef logic [paBits-1:0] paddr_t;
  typedef logic [tagBits-1:0] tag_t;
  typedef logic [indexBits-1:0] index_t;
  typedef logic [lineBits-1:0] line_t;
  typedef logic [numWays-1:0] way_t;

endpackage

`default_nettype wire

/* logic/fetchPkg.sv */
/*
  Types seen on the fetch side and on the line-fill bus, plus the
  controller state encoding and the read-address select codes.
*/

`default_nettype none

package fetchPkg;

  // Line request toward memory, adr is always line aligned
  typedef struct packed {
    logic fetchLine;
    cacheGeomPkg::paddr_t adr;
  } memReq_t;

  // Ack is a single-cycle pulse carrying the whole line
  typedef struct packed {
    logic ack;
    cacheGeomPkg::line_t data;
  } memRsp_t;

  // Raw instruction as fetched, never expanded
  typedef struct packed {
    logic [31:0] instrRaw;
    logic compressed;
  } fetchOut_t;

  typedef enum logic [2:0] {
    stateReady,
    stateMissFetch,
    stateMissWrite,
    stateSpillRead,
    stateSpillFetch,
    stateSpillWrite,
    stateUncachedDone
  } ctrlState_e;

  // Read-address select, bit 1 marks the spill address
  localparam logic [1:0] selNext = 2'b00;
  localparam logic [1:0] selPc = 2'b01;
  localparam logic [1:0] selSpill = 2'b10;

endpackage

`default_nettype wire

/* logic/cacheWay.sv */
/*
  One way of the instruction cache. Tag and data arrays read one cycle
  after the index is presented; the hit compare then uses the tag of the
  address that was actually read. The line leaves the way masked by its
  hit, so the top level can OR the ways together.
*/

`timescale 1ns/1ps
`default_nettype none

module cacheWay (
  input  logic                 clk,
  input  logic                 rstN,
  input  cacheGeomPkg::index_t rdIndex,
  input  cacheGeomPkg::tag_t   tag,
  input  logic                 wrEn,
  input  cacheGeomPkg::line_t  wrData,
  input  logic                 invalidateAll,
  output cacheGeomPkg::line_t  hitLine,
  output logic                 hit
);

  cacheGeomPkg::tag_t tagMem [cacheGeomPkg::numSets];
  cacheGeomPkg::line_t dataMem [cacheGeomPkg::numSets];
  logic [cacheGeomPkg::numSets-1:0] validBits;

  // Index of the set now on the array outputs, also the fill target
  cacheGeomPkg::index_t idxQ;
  cacheGeomPkg::tag_t tagQ;
  cacheGeomPkg::line_t dataQ;

  ////////////////////
  // Arrays
  ////////////////////

  // A fill lands in the set currently being compared
  // Read during write returns the old entry, hence the reread after a fill
  always_ff @(posedge clk) begin
    if (wrEn) begin
      tagMem[idxQ] <= tag;
      dataMem[idxQ] <= wrData;
    end
    tagQ <= tagMem[rdIndex];
    dataQ <= dataMem[rdIndex];
  end

  // Valid bits live in flops so a whole-cache invalidate takes one edge
  // The fill write comes last so a fill racing an invalidate survives
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validBits <= '0;
      idxQ <= '0;
    end else begin
      idxQ <= rdIndex;
      if (invalidateAll) begin
        validBits <= '0;
      end
      if (wrEn) begin
        validBits[idxQ] <= 1'b1;
      end
    end
  end

  ////////////////////
  // Compare
  ////////////////////

  // Valid is read from the flops, so an invalidate hides the entry from the next cycle
  assign hit = validBits[idxQ] & (tagQ == tag);

  // First half of the AND-OR line mux
  assign hitLine = hit ? dataQ : '0;

endmodule

`default_nettype wire

/* logic/replacementLru.sv */
/*
  Pseudo-LRU for the two-way cache, one bit per set. The bit names the
  way that was used least recently, and that way is the fill victim.
  The set follows the array read index, one cycle late like the ways.
*/

`timescale 1ns/1ps
`default_nettype none

module replacementLru (
  input  logic                 clk,
  input  logic                 rstN,
  input  cacheGeomPkg::index_t rdIndex,
  input  cacheGeomPkg::way_t   wayHit,
  input  logic                 touchEn,
  output cacheGeomPkg::way_t   victim
);

  // Set 1 means way 1 is the older one
  logic [cacheGeomPkg::numSets-1:0] lruBits;
  cacheGeomPkg::index_t idxQ;

  // Touch points the bit at the way that was not used
  always_ff @(posedge clk) begin
    if (!rstN) begin
      lruBits <= '0;
      idxQ <= '0;
    end else begin
      idxQ <= rdIndex;
      if (touchEn) begin
        lruBits[idxQ] <= wayHit[0];
      end
    end
  end

  // One-hot victim for the set being compared
  assign victim = lruBits[idxQ] ? 2'b10 : 2'b01;

endmodule

`default_nettype wire

/* logic/iCacheFsm.sv */
/*
  Controller of the instruction cache. It picks the next read address,
  raises the line request on a miss, and steps through the two halves of
  a fetch that crosses a line. Outputs decode from the state and inputs.
*/

`timescale 1ns/1ps
`default_nettype none

module iCacheFsm (
  input  logic       clk,
  input  logic       rstN,
  input  logic       hit,
  input  logic       spill,
  input  logic       cacheable,
  input  logic       cpuBusy,
  input  logic       invalidate,
  input  logic       ack,
  output logic [1:0] selAdr,
  output logic       fillEn,
  output logic       spillSave,
  output logic       lruTouch,
  output logic       fetchLine,
  output logic       stall,
  output logic       uncachedSel
);

  fetchPkg::ctrlState_e state;
  fetchPkg::ctrlState_e stateNext;

  // Array outputs mean nothing until one read has been issued since reset
  logic readPrimed;
  logic hitOk;

  // An uncacheable fetch never trusts a stale copy in the arrays
  assign hitOk = hit & cacheable;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= fetchPkg::stateReady;
      readPrimed <= 1'b0;
    end else begin
      state <= stateNext;
      readPrimed <= 1'b1;
    end
  end

  ////////////////////
  // Next state and outputs
  ////////////////////

  always_comb begin
    stateNext = state;
    selAdr = fetchPkg::selPc;
    fillEn = 1'b0;
    spillSave = 1'b0;
    lruTouch = 1'b0;
    fetchLine = 1'b0;
    stall = 1'b1;
    uncachedSel = 1'b0;
    case (state)
      fetchPkg::stateReady: begin
        if (!readPrimed) begin
          stall = 1'b0;
          selAdr = fetchPkg::selNext;
        end else if (spill && hitOk) begin
          // Keep the last halfword, then go read the following line
          spillSave = 1'b1;
          lruTouch = !invalidate;
          selAdr = fetchPkg::selSpill;
          stateNext = fetchPkg::stateSpillWrite;
        end else if (!hitOk) begin
          stateNext = fetchPkg::stateMissFetch;
        end else begin
          // Plain hit; while busy the same pc is reread and not retouched
          stall = 1'b0;
          lruTouch = !cpuBusy && !invalidate;
          selAdr = cpuBusy ? fetchPkg::selPc : fetchPkg::selNext;
        end
      end
      fetchPkg::stateMissFetch: begin
        fetchLine = 1'b1;
        if (ack && cacheable) begin
          fillEn = 1'b1;
          lruTouch = 1'b1;
          stateNext = fetchPkg::stateMissWrite;
        end else if (ack && spill) begin
          // Uncached first half of a spill is taken straight off the bus
          uncachedSel = 1'b1;
          spillSave = 1'b1;
          selAdr = fetchPkg::selSpill;
          stateNext = fetchPkg::stateSpillWrite;
        end else if (ack) begin
          uncachedSel = 1'b1;
          stateNext = fetchPkg::stateUncachedDone;
        end
      end
      // Reread of the freshly written set
      fetchPkg::stateMissWrite: begin
        stateNext = fetchPkg::stateReady;
      end
      fetchPkg::stateSpillWrite: begin
        selAdr = fetchPkg::selSpill;
        stateNext = fetchPkg::stateSpillRead;
      end
      fetchPkg::stateSpillRead: begin
        selAdr = fetchPkg::selSpill;
        if (!hitOk) begin
          stateNext = fetchPkg::stateSpillFetch;
        end else begin
          // Merged word is on the outputs now
          stall = 1'b0;
          if (!cpuBusy) begin
            selAdr = fetchPkg::selNext;
            lruTouch = !invalidate;
            stateNext = fetchPkg::stateReady;
          end
        end
      end
      fetchPkg::stateSpillFetch: begin
        fetchLine = 1'b1;
        selAdr = fetchPkg::selSpill;
        if (ack && cacheable) begin
          fillEn = 1'b1;
          lruTouch = 1'b1;
          stateNext = fetchPkg::stateSpillWrite;
        end else if (ack) begin
          uncachedSel = 1'b1;
          stateNext = fetchPkg::stateUncachedDone;
        end
      end
      fetchPkg::stateUncachedDone: begin
        // The word captured at the ack is presented until the CPU takes it
        stall = 1'b0;
        uncachedSel = 1'b1;
        if (!cpuBusy) begin
          selAdr = fetchPkg::selNext;
          stateNext = fetchPkg::stateReady;
        end
      end
      default: begin
        stateNext = fetchPkg::stateReady;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/iCache.sv */
/*
  Instruction cache top level. Arrays are read with the next PC so a hit
  returns the instruction in the cycle its pc is presented. Misses fill
  whole lines over the request/ack bus; fetches that straddle two lines
  are merged from a saved halfword. stall marks every wait.
*/

`timescale 1ns/1ps
`default_nettype none

module iCache (
  input  logic                 clk,
  input  logic                 rstN,
  input  cacheGeomPkg::paddr_t pcNext,
  input  cacheGeomPkg::paddr_t pc,
  input  logic                 cacheable,
  input  logic                 cpuBusy,
  input  logic                 invalidate,
  output fetchPkg::fetchOut_t  fetch,
  output logic                 stall,
  output fetchPkg::memReq_t    memReq,
  input  fetchPkg::memRsp_t    memRsp
);

  localparam int halfSelBits = $clog2(cacheGeomPkg::halvesPerLine);

  logic [1:0] selAdr;
  logic selSpillQ;
  logic fillEn, spillSave, lruTouch, fetchLine, uncachedSel;
  logic hit, spill;
  cacheGeomPkg::paddr_t pcSpill, rdAdr, cmpAdr;
  cacheGeomPkg::index_t rdIndex;
  cacheGeomPkg::way_t wayHit, victim, lruWay, wayWrEn;
  cacheGeomPkg::line_t wayLine [cacheGeomPkg::numWays];
  cacheGeomPkg::line_t cacheLine, lineSel;
  logic [halfSelBits-1:0] halfSel;
  logic [31:0] winWord, busWord, word, instr;
  logic [15:0] spillHalf;

  ////////////////////
  // Address select
  ////////////////////

  // A spill sits on the last halfword, so pc+2 is the next line at offset 0
  assign pcSpill = pc + cacheGeomPkg::paBits'(2);

  always_comb begin
    case (selAdr)
      fetchPkg::selPc: rdAdr = pc;
      fetchPkg::selSpill: rdAdr = pcSpill;
      default: rdAdr = pcNext;
    endcase
  end
  assign rdIndex = rdAdr[cacheGeomPkg::offsetBits +: cacheGeomPkg::indexBits];

  // The compare happens a cycle after the read, so the select is delayed too
  always_ff @(posedge clk) begin
    if (!rstN) begin
      selSpillQ <= 1'b0;
    end else begin
      selSpillQ <= (selAdr == fetchPkg::selSpill);
    end
  end
  assign cmpAdr = selSpillQ ? pcSpill : pc;

  ////////////////////
  // Ways and LRU
  ////////////////////

  for (genvar w = 0; w < cacheGeomPkg::numWays; w++) begin : gWay
    cacheWay u_way (
      .clk,
      .rstN,
      .rdIndex,
      .tag(cmpAdr[cacheGeomPkg::paBits-1 -: cacheGeomPkg::tagBits]),
      .wrEn(wayWrEn[w]),
      .wrData(memRsp.data),
      .invalidateAll(invalidate),
      .hitLine(wayLine[w]),
      .hit(wayHit[w])
    );
  end

  assign hit = |wayHit;
  assign wayWrEn = fillEn ? victim : '0;
  // A fill counts as a use of the way it lands in
  assign lruWay = fillEn ? victim : wayHit;

  replacementLru u_lru (
    .clk,
    .rstN,
    .rdIndex,
    .wayHit(lruWay),
    .touchEn(lruTouch),
    .victim
  );

  ////////////////////
  // Instruction select
  ////////////////////

  // Second half of the AND-OR mux; uncached lines bypass the arrays
  assign cacheLine = wayLine[0] | wayLine[1];
  assign lineSel = uncachedSel ? memRsp.data : cacheLine;

  // Shifting in zeros leaves the upper half empty at the last halfword
  assign halfSel = cmpAdr[cacheGeomPkg::offsetBits-1:1];
  assign winWord = 32'(lineSel >> {halfSel, 4'b0000});

  // Bus data lasts one cycle, the word is held for the cycles after the ack
  always_ff @(posedge clk) begin
    if (uncachedSel && memRsp.ack) begin
      busWord <= winWord;
    end
    if (spillSave) begin
      spillHalf <= word[15:0];
    end
  end
  assign word = (uncachedSel && !memRsp.ack) ? busWord : winWord;

  assign spill = &pc[cacheGeomPkg::offsetBits-1:1];
  assign instr = spill ? {word[15:0], spillHalf} : word;

  assign fetch.instrRaw = instr;
  assign fetch.compressed = (instr[1:0] != 2'b11);

  assign memReq.fetchLine = fetchLine;
  assign memReq.adr = {cmpAdr[cacheGeomPkg::paBits-1:cacheGeomPkg::offsetBits],
                       cacheGeomPkg::offsetBits'(0)};

  iCacheFsm u_fsm (
    .clk,
    .rstN,
    .hit,
    .spill,
    .cacheable,
    .cpuBusy,
    .invalidate,
    .ack(memRsp.ack),
    .selAdr,
    .fillEn,
    .spillSave,
    .lruTouch,
    .fetchLine,
    .stall,
    .uncachedSel
  );

endmodule

`default_nettype wire

/* verification/iCache_sva.sv */
/*
  Protocol assertions for the instruction cache, bound to the top level.
  They watch the line-fill bus and the stall output after reset.
*/

`timescale 1ns/1ps
`default_nettype none

module iCacheSva (
  input logic              clk,
  input logic              rstN,
  input logic              stall,
  input fetchPkg::memReq_t memReq,
  input fetchPkg::memRsp_t memRsp
);

  // Request level and address stay put until the ack pulse
  reqHold: assert property (@(posedge clk) disable iff (!rstN)
    memReq.fetchLine && !memRsp.ack |=> memReq.fetchLine && $stable(memReq.adr))
    else $error("line request dropped or moved before its ack");

  // Memory only answers an open request
  ackOnRequest: assert property (@(posedge clk) disable iff (!rstN)
    memRsp.ack |-> memReq.fetchLine)
    else $error("ack seen without a line request");

  // No fetch is pending yet in the first cycle out of reset
  idleAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !stall)
    else $error("stall high in the first cycle after reset");

endmodule

`default_nettype wire

/* verification/iCacheTb.sv */
/*
  Testbench for the instruction cache. Fetch PCs, flags and expected words
  come from the input file, and a line memory model answers the fill bus
  after a random delay. Run from the project root so the file is found.
*/

`timescale 1ns/1ps
`default_nettype none

module iCacheTb;

  localparam int fieldsPerFetch = 6;
  localparam int maxFetches = 64;
  localparam int waitLimit = 200;
  localparam logic [31:0] endMark = 32'hFFFF_FFFF;

  logic clk = 1'b0;
  logic rstN;
  cacheGeomPkg::paddr_t pcNext;
  cacheGeomPkg::paddr_t pc;
  logic cacheable;
  logic cpuBusy;
  logic invalidate;
  fetchPkg::fetchOut_t fetch;
  logic stall;
  fetchPkg::memReq_t memReq;
  fetchPkg::memRsp_t memRsp;

  // Six words per fetch: pc, cacheable, invalidate, instrRaw, compressed, fills
  logic [31:0] stim [fieldsPerFetch*maxFetches];
  integer seed;
  integer fillCount;
  integer ackDelay;
  logic reqOpen;
  int numFetches;

  iCache u_dut (
    .clk, .rstN, .pcNext, .pc, .cacheable, .cpuBusy, .invalidate,
    .fetch, .stall, .memReq, .memRsp
  );

  bind iCache iCacheSva u_sva (
    .clk(clk), .rstN(rstN), .stall(stall), .memReq(memReq), .memRsp(memRsp)
  );

  always #5 clk = ~clk;

  ////////////////////
  // Memory model
  ////////////////////

  // Every halfword holds its own halfword address, scrambled
  function automatic logic [15:0] memHalf(input cacheGeomPkg::paddr_t adr);
    return adr[16:1] ^ 16'h5A3C;
  endfunction

  function automatic cacheGeomPkg::paddr_t lineBase(input cacheGeomPkg::paddr_t adr);
    return adr & ~cacheGeomPkg::paddr_t'(cacheGeomPkg::lineBits / 8 - 1);
  endfunction

  function automatic cacheGeomPkg::line_t memLine(input cacheGeomPkg::paddr_t base);
    cacheGeomPkg::line_t line;
    for (int j = 0; j < cacheGeomPkg::halvesPerLine; j++) begin
      line[16*j +: 16] = memHalf(base + 2 * j);
    end
    return line;
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkFetch(input fetchPkg::fetchOut_t expected,
                            input fetchPkg::fetchOut_t actual);
    if (actual !== expected) begin
      stopOnError($sformatf("FAILED at %0t: fetch expected %h/%0b actual %h/%0b", $time,
                            expected.instrRaw, expected.compressed,
                            actual.instrRaw, actual.compressed));
    end
  endtask

  task automatic checkAdr(input cacheGeomPkg::paddr_t expected,
                          input cacheGeomPkg::paddr_t actual);
    if (actual !== expected) begin
      stopOnError($sformatf("FAILED at %0t: memReq.adr expected %h actual %h",
                            $time, expected, actual));
    end
  endtask

  task automatic checkFills(input integer expected, input integer actual);
    if (actual !== expected) begin
      stopOnError($sformatf("FAILED at %0t: fill count expected %0d actual %0d",
                            $time, expected, actual));
    end
  endtask

  // Runs at each falling edge, the ack is a single-cycle pulse
  task automatic serveMemory();
    cacheGeomPkg::paddr_t expAdr;
    if (memRsp.ack) begin
      memRsp.ack = 1'b0;
      reqOpen = 1'b0;
    end else if (memReq.fetchLine) begin
      if (!reqOpen) begin
        reqOpen = 1'b1;
        fillCount++;
        expAdr = lineBase(pc);
        // The second half of a spill asks for the following line
        if ((&pc[cacheGeomPkg::offsetBits-1:1]) && memReq.adr == lineBase(pc + 2)) begin
          expAdr = lineBase(pc + 2);
        end
        checkAdr(expAdr, memReq.adr);
        ackDelay = $random(seed) & 7;
      end
      if (ackDelay == 0) begin
        memRsp.ack = 1'b1;
        memRsp.data = memLine(memReq.adr);
      end else begin
        ackDelay--;
      end
    end
  endtask

  task automatic advance();
    @(negedge clk);
    serveMemory();
  endtask

  ////////////////////
  // Fetch sequence
  ////////////////////

  task automatic runFetch(input int idx);
    cacheGeomPkg::paddr_t fetchPc;
    fetchPkg::fetchOut_t expected;
    logic invFlag;
    integer expFills;
    integer fillsBefore;
    int waited;
    int base;
    base = idx * fieldsPerFetch;
    fetchPc = stim[base];
    invFlag = stim[base + 2][0];
    expected.instrRaw = stim[base + 3];
    expected.compressed = stim[base + 4][0];
    expFills = stim[base + 5];
    fillsBefore = fillCount;
    advance();
    pc = fetchPc;
    // The next fetch is read ahead, the last one just repeats itself
    pcNext = (idx + 1 < numFetches) ? stim[base + fieldsPerFetch] : fetchPc;
    cacheable = stim[base + 1][0];
    invalidate = invFlag;
    // A busy CPU keeps the stale hit of the invalidate cycle from being taken
    cpuBusy = invFlag | (($random(seed) & 3) == 0);
    #1;
    waited = 0;
    while (stall || cpuBusy) begin
      if (waited == waitLimit) begin
        stopOnError($sformatf("stall did not fall within %0d cycles for pc %h",
                              waitLimit, fetchPc));
      end
      waited++;
      advance();
      invalidate = 1'b0;
      cpuBusy = (($random(seed) & 3) == 0);
      #1;
    end
    checkFetch(expected, fetch);
    checkFills(expFills, fillCount - fillsBefore);
  endtask

  initial begin
    seed = 32'h3967_ca88;
    rstN = 1'b0;
    pc = '0;
    pcNext = '0;
    cacheable = 1'b1;
    cpuBusy = 1'b0;
    invalidate = 1'b0;
    memRsp = '0;
    fillCount = 0;
    ackDelay = 0;
    reqOpen = 1'b0;
    for (int k = 0; k < fieldsPerFetch * maxFetches; k++) begin
      stim[k] = endMark;
    end
    $readmemh("verification/fetchInput.txt", stim);
    numFetches = 0;
    while (numFetches < maxFetches && stim[fieldsPerFetch*numFetches] != endMark) begin
      numFetches++;
    end
    if (numFetches == 0) begin
      stopOnError("the input file holds no fetches");
    end
    // The first PC is read as the controller leaves reset
    pcNext = stim[0];
    repeat (10) @(negedge clk);
    rstN = 1'b1;
    for (int i = 0; i < numFetches; i++) begin
      runFetch(i);
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/fetchInput.txt */
// pc cacheable invalidate instrRaw compressed fills, all hex, one fetch per line
// instrRaw is {half(pc+2), half(pc)}, where half(a) = a[16:1] ^ 5a3c
00000100 1 0 5abd5abc 1 1
00000104 1 0 5abf5abe 1 0
00000106 1 0 5ab85abf 0 0
0000010e 1 0 5ab45abb 0 1
0000011e 1 0 5aac5ab3 0 1
0000010e 1 0 5ab45abb 0 0
0000013e 1 0 5a9c5aa3 0 2
00001070 1 0 52055204 1 1
00002072 1 0 4a064a05 1 1
00001074 1 0 52075206 1 0
00003076 1 0 42004207 0 1
00001078 1 0 52015200 1 0
0000207a 1 0 4a024a01 1 1
00000108 1 1 5ab95ab8 1 1
0000010a 1 0 5aba5ab9 1 0
00000150 0 0 5a955a94 1 1
00000150 0 0 5a955a94 1 1
00000154 1 0 5a975a96 1 1
00000156 1 0 5a905a97 0 0
00000104 0 0 5abf5abe 1 1
00000102 1 0 5abe5abd 1 0
0000010e 1 0 5ab45abb 0 1

/* iCache.f */
logic/cacheGeomPkg.sv
logic/fetchPkg.sv
logic/cacheWay.sv
logic/replacementLru.sv
logic/iCacheFsm.sv
logic/iCache.sv
verification/iCache_sva.sv
verification/iCacheTb.sv

/* Bender.yml */
package:
  name: icache

sources:
  # Packages first, geometry before the fetch types that use it
  - logic/cacheGeomPkg.sv
  - logic/fetchPkg.sv
  # Cache RTL
  - logic/cacheWay.sv
  - logic/replacementLru.sv
  - logic/iCacheFsm.sv
  - logic/iCache.sv
  # Testbench and bound assertions
  - target: simulation
    files:
      - verification/iCache_sva.sv
      - verification/iCacheTb.sv
